// File: logic/rob_consts.svh
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// reorder buffer geometry
`define ROB_DEPTH 8
`define ROB_IDX_W 3

// datapath and register index widths
`define XLEN 32
`define RD_W 5

// result queue behind the alu lane
`define RESQ_DEPTH 4

// host register map
`define WB_ADR_W 2
`define WB_ADDR_OPA 2'd0
`define WB_ADDR_OPB 2'd1
`define WB_ADDR_INSTR 2'd2

`endif

// File: logic/rv32i_pkg.sv
package rv32i_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        BRANCH = 7'b1100011
    } opcode_t;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // funct7 values, alt selects sub
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // what the execute unit does with an instruction
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        BR_EQ,
        BR_NE,
        ILLEGAL
    } op_class_t;

endpackage

// File: logic/tomasulo_pkg.sv
`include "rob_consts.svh"

package tomasulo_pkg;

    // reorder buffer slot number
    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

    // epoch bit lets the buffer tell squashed results apart
    typedef struct packed {
        logic     epoch;
        rob_idx_t idx;
    } rob_tag_t;

    // operation sent from decode to execute
    typedef struct packed {
        rob_tag_t              tag;
        rv32i_pkg::op_class_t  op;
        logic [`XLEN-1:0]      opa;
        // immediate already substituted for op_imm
        logic [`XLEN-1:0]      opb;
        logic [`XLEN-1:0]      offset;
    } issue_t;

    // common data bus word
    // for branches the value field carries the branch offset
    typedef struct packed {
        rob_tag_t         tag;
        logic [`XLEN-1:0] value;
        logic             taken;
    } cdb_t;

endpackage

// File: logic/cdb_if.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

interface cdb_if;

    // allocation handshake, decode to reorder buffer
    logic                   alloc_req;
    logic [`RD_W-1:0]       alloc_rd;
    logic [`XLEN-1:0]       alloc_pc;
    logic                   alloc_is_branch;
    logic                   alloc_grant;
    tomasulo_pkg::rob_tag_t alloc_tag;

    // issue into execute
    logic                   issue_valid;
    tomasulo_pkg::issue_t   issue;

    // common data bus
    logic                   result_valid;
    tomasulo_pkg::cdb_t     result;

    // pc reload after a taken branch
    logic                   redirect;
    logic [`XLEN-1:0]       redirect_pc;

    modport decode (
        output alloc_req, alloc_rd, alloc_pc, alloc_is_branch, issue_valid, issue,
        input  alloc_grant, alloc_tag
    );

    modport rob (
        input  alloc_req, alloc_rd, alloc_pc, alloc_is_branch, result_valid, result,
        output alloc_grant, alloc_tag
    );

    modport exec (
        input  issue_valid, issue,
        output result_valid, result
    );

    // driven by the reorder buffer, the decoder only reads it
    modport flush (
        output redirect, redirect_pc
    );

endinterface

// File: logic/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type PAYLOAD_T = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  PAYLOAD_T push_data,
    input  logic     pop,
    input  logic     clear_younger,
    output PAYLOAD_T pop_data,
    output logic     not_empty,
    output logic     full
);
    // depth is a power of two so pointers wrap on their own
    localparam int PW = $clog2(DEPTH);

    PAYLOAD_T      mem [DEPTH];
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [PW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign not_empty = (count != '0);
    assign full      = (count == (PW+1)'(DEPTH));
    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;
    assign pop_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (clear_younger) begin
                // keep just the head, and not even that if it pops now
                wr_ptr <= rd_ptr + PW'(not_empty);
                count  <= (PW+1)'(not_empty && !do_pop);
            end else begin
                if (do_push) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                count <= count + (PW+1)'(do_push) - (PW+1)'(do_pop);
            end
        end
    end

endmodule

// File: logic/dispatch_decode.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module dispatch_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  logic [`WB_ADR_W-1:0] adr,
    input  logic [`XLEN-1:0]     dat_w,
    output logic [`XLEN-1:0]     dat_r,
    output logic                 ack,
    cdb_if.decode                dec,
    cdb_if.flush                 fl
);
    logic                 req;
    logic                 instr_wr;
    logic [`XLEN-1:0]     opa;
    logic [`XLEN-1:0]     opb;
    logic [`XLEN-1:0]     opb_eff;
    logic [`XLEN-1:0]     pc;
    logic [`XLEN-1:0]     imm_i;
    logic [`XLEN-1:0]     imm_b;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    rv32i_pkg::opcode_t   opcode;
    rv32i_pkg::op_class_t op;

    // new request only while no ack is out, master drops stb after ack
    assign req      = cyc && stb && !ack;
    assign instr_wr = req && we && (adr == `WB_ADDR_INSTR);

    // instruction fields
    assign opcode = rv32i_pkg::opcode_t'(dat_w[6:0]);
    assign funct3 = dat_w[14:12];
    assign funct7 = dat_w[31:25];
    assign imm_i  = {{20{dat_w[31]}}, dat_w[31:20]};
    assign imm_b  = {{19{dat_w[31]}}, dat_w[31], dat_w[7], dat_w[30:25], dat_w[11:8], 1'b0};

    // classify, anything outside the subset is illegal
    always_comb begin
        op      = rv32i_pkg::ILLEGAL;
        opb_eff = opb;
        case (opcode)
            rv32i_pkg::OP: begin
                if (funct3 == rv32i_pkg::F3_ADD_SUB && funct7 == rv32i_pkg::F7_BASE) begin
                    op = rv32i_pkg::ALU_ADD;
                end else if (funct3 == rv32i_pkg::F3_ADD_SUB && funct7 == rv32i_pkg::F7_ALT) begin
                    op = rv32i_pkg::ALU_SUB;
                end else if (funct3 == rv32i_pkg::F3_XOR && funct7 == rv32i_pkg::F7_BASE) begin
                    op = rv32i_pkg::ALU_XOR;
                end
            end
            rv32i_pkg::OP_IMM: begin
                // immediate replaces operand b
                opb_eff = imm_i;
                if (funct3 == rv32i_pkg::F3_ADD_SUB) begin
                    op = rv32i_pkg::ALU_ADD;
                end else if (funct3 == rv32i_pkg::F3_XOR) begin
                    op = rv32i_pkg::ALU_XOR;
                end
            end
            rv32i_pkg::BRANCH: begin
                if (funct3 == rv32i_pkg::F3_BEQ) begin
                    op = rv32i_pkg::BR_EQ;
                end else if (funct3 == rv32i_pkg::F3_BNE) begin
                    op = rv32i_pkg::BR_NE;
                end
            end
            default: ;
        endcase
    end

    // illegal words are acked but never reach the buffer
    assign dec.alloc_req       = instr_wr && (op != rv32i_pkg::ILLEGAL);
    assign dec.alloc_rd        = dat_w[11:7];
    assign dec.alloc_pc        = pc;
    assign dec.alloc_is_branch = (op == rv32i_pkg::BR_EQ) || (op == rv32i_pkg::BR_NE);
    assign dec.issue_valid     = dec.alloc_req && dec.alloc_grant;
    assign dec.issue = '{tag: dec.alloc_tag, op: op, opa: opa, opb: opb_eff, offset: imm_b};

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
            pc  <= '0;
        end else begin
            // instruction writes wait for a free slot
            ack <= req && (!instr_wr || op == rv32i_pkg::ILLEGAL || dec.alloc_grant);
            if (fl.redirect) begin
                pc <= fl.redirect_pc;
            end else if (dec.issue_valid) begin
                pc <= pc + `XLEN'(4);
            end
        end
    end

    // operand latches and read data
    always_ff @(posedge clk) begin
        if (req && we && adr == `WB_ADDR_OPA) begin
            opa <= dat_w;
        end
        if (req && we && adr == `WB_ADDR_OPB) begin
            opb <= dat_w;
        end
        if (req && !we) begin
            dat_r <= pc;
        end
    end

    // the buffer refuses slots while a pc reload is in progress
    assert property (@(posedge clk) disable iff (rst)
        dec.issue_valid |-> !fl.redirect);

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module exec_unit (
    input  logic clk,
    input  logic rst,
    cdb_if.exec  ex
);
    logic               alu_valid;
    logic [`XLEN-1:0]   alu_value;
    tomasulo_pkg::cdb_t alu_res;
    logic               br_issue;
    logic               br_taken;
    tomasulo_pkg::cdb_t q_data;
    logic               q_not_empty;
    logic               q_full;
    logic               q_pop;
    // branch lane stages, index 2 is the oldest
    logic [2:0]         br_v;
    tomasulo_pkg::cdb_t br_d [3];

    assign alu_valid = ex.issue_valid && (ex.issue.op == rv32i_pkg::ALU_ADD ||
                                          ex.issue.op == rv32i_pkg::ALU_SUB ||
                                          ex.issue.op == rv32i_pkg::ALU_XOR);
    assign br_issue  = ex.issue_valid && (ex.issue.op == rv32i_pkg::BR_EQ ||
                                          ex.issue.op == rv32i_pkg::BR_NE);

    // single cycle alu
    always_comb begin
        alu_value = ex.issue.opa + ex.issue.opb;
        case (ex.issue.op)
            rv32i_pkg::ALU_SUB: alu_value = ex.issue.opa - ex.issue.opb;
            rv32i_pkg::ALU_XOR: alu_value = ex.issue.opa ^ ex.issue.opb;
            default: ;
        endcase
    end

    assign alu_res  = '{tag: ex.issue.tag, value: alu_value, taken: 1'b0};
    // bne inverts the equality compare
    assign br_taken = (ex.issue.opa == ex.issue.opb) ^ (ex.issue.op == rv32i_pkg::BR_NE);

    sync_fifo #(
        .PAYLOAD_T (tomasulo_pkg::cdb_t),
        .DEPTH     (`RESQ_DEPTH)
    ) result_queue (
        .clk           (clk),
        .rst           (rst),
        .push          (alu_valid),
        .push_data     (alu_res),
        .pop           (q_pop),
        .clear_younger (1'b0),
        .pop_data      (q_data),
        .not_empty     (q_not_empty),
        .full          (q_full)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            br_v <= '0;
        end else begin
            br_v <= {br_v[1:0], br_issue};
        end
    end

    // offset rides along so the buffer can form the target
    always_ff @(posedge clk) begin
        br_d[0] <= '{tag: ex.issue.tag, value: ex.issue.offset, taken: br_taken};
        br_d[1] <= br_d[0];
        br_d[2] <= br_d[1];
    end

    // branch lane has priority, alu results wait in the queue
    assign q_pop           = q_not_empty && !br_v[2];
    assign ex.result_valid = br_v[2] || q_not_empty;
    assign ex.result       = br_v[2] ? br_d[2] : q_data;

    // one alu push per cycle against one bus slot per cycle keeps the queue short
    assert property (@(posedge clk) disable iff (rst) alu_valid |-> !q_full);

endmodule

// File: logic/reorder_buffer.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module reorder_buffer (
    input  logic               clk,
    input  logic               rst,
    cdb_if.rob                 rb,
    cdb_if.flush               fl,
    output logic               commit_valid,
    output logic [`XLEN-1:0]   commit_pc,
    output logic [`RD_W-1:0]   commit_rd,
    output logic [`XLEN-1:0]   commit_value
);
    localparam int IW = `ROB_IDX_W;

    // per entry state
    logic             alloc_arr    [`ROB_DEPTH];
    logic             complete_arr [`ROB_DEPTH];
    logic             branch_arr   [`ROB_DEPTH];
    logic             taken_arr    [`ROB_DEPTH];
    logic [`RD_W-1:0] rd_arr       [`ROB_DEPTH];
    logic [`XLEN-1:0] pc_arr       [`ROB_DEPTH];
    logic [`XLEN-1:0] value_arr    [`ROB_DEPTH];
    logic             younger      [`ROB_DEPTH];

    logic [IW-1:0]          head;
    logic [IW-1:0]          tail;
    logic [IW:0]            count;
    logic                   epoch;
    logic [IW-1:0]          res_idx;
    logic [IW-1:0]          age_br;
    tomasulo_pkg::rob_idx_t bq_idx;
    logic                   bq_not_empty;
    logic                   bq_push;
    logic                   bus_hit;
    logic                   head_on_bus;
    logic                   resolve;
    logic                   res_taken;
    logic [`XLEN-1:0]       res_offset;
    logic                   squash;
    logic                   retire;

    // no grant while full or while the redirect pulse is out
    assign rb.alloc_grant = rb.alloc_req && (count != (IW+1)'(`ROB_DEPTH)) && !fl.redirect;
    assign rb.alloc_tag   = {epoch, tail};
    assign bq_push        = rb.alloc_grant && rb.alloc_is_branch;

    // stale epoch results belong to squashed work
    assign res_idx = rb.result.tag.idx;
    assign bus_hit = rb.result_valid && (rb.result.tag.epoch == epoch) && alloc_arr[res_idx];

    // oldest unresolved branch resolves from the bus or from a stored result
    assign head_on_bus = bus_hit && (res_idx == bq_idx);
    assign resolve     = bq_not_empty && (complete_arr[bq_idx] || head_on_bus);
    assign res_taken   = complete_arr[bq_idx] ? taken_arr[bq_idx] : rb.result.taken;
    assign res_offset  = complete_arr[bq_idx] ? value_arr[bq_idx] : rb.result.value;
    assign squash      = resolve && res_taken;

    // an unresolved branch holds the head until the cycle after it resolves
    assign retire = alloc_arr[head] && complete_arr[head] && !(bq_not_empty && bq_idx == head);

    // entries past the branch in age order
    assign age_br = bq_idx - head;
    always_comb begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            younger[i] = (IW'(i) - head) > age_br;
        end
    end

    sync_fifo #(
        .PAYLOAD_T (tomasulo_pkg::rob_idx_t),
        .DEPTH     (`ROB_DEPTH)
    ) branch_queue (
        .clk           (clk),
        .rst           (rst),
        .push          (bq_push),
        .push_data     (tail),
        .pop           (resolve),
        .clear_younger (squash),
        .pop_data      (bq_idx),
        .not_empty     (bq_not_empty),
        .full          ()
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                alloc_arr[i]    <= 1'b0;
                complete_arr[i] <= 1'b0;
            end
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            epoch        <= 1'b0;
            fl.redirect  <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            fl.redirect  <= squash;
            commit_valid <= retire;
            if (rb.alloc_grant) begin
                alloc_arr[tail]    <= 1'b1;
                complete_arr[tail] <= 1'b0;
                tail               <= tail + 1'b1;
            end
            if (bus_hit) begin
                complete_arr[res_idx] <= 1'b1;
            end
            if (retire) begin
                alloc_arr[head]    <= 1'b0;
                complete_arr[head] <= 1'b0;
                head               <= head + 1'b1;
            end
            if (squash) begin
                // also drops an entry allocated in this same cycle
                for (int i = 0; i < `ROB_DEPTH; i++) begin
                    if (younger[i]) begin
                        alloc_arr[i]    <= 1'b0;
                        complete_arr[i] <= 1'b0;
                    end
                end
                tail  <= bq_idx + 1'b1;
                epoch <= ~epoch;
                count <= (IW+1)'(age_br) + 1'b1 - (IW+1)'(retire);
            end else begin
                count <= count + (IW+1)'(rb.alloc_grant) - (IW+1)'(retire);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rb.alloc_grant) begin
            branch_arr[tail] <= rb.alloc_is_branch;
            rd_arr[tail]     <= rb.alloc_rd;
            pc_arr[tail]     <= rb.alloc_pc;
        end
        if (bus_hit) begin
            value_arr[res_idx] <= rb.result.value;
            taken_arr[res_idx] <= rb.result.taken;
        end
        // branches write no register
        if (retire) begin
            commit_pc    <= pc_arr[head];
            commit_rd    <= branch_arr[head] ? '0 : rd_arr[head];
            commit_value <= value_arr[head];
        end
        if (squash) begin
            fl.redirect_pc <= pc_arr[bq_idx] + res_offset;
        end
    end

    // pointers agree with occupancy through alloc, retire and squash
    assert property (@(posedge clk) disable iff (rst)
        (head == tail) |-> (count == '0 || count == (IW+1)'(`ROB_DEPTH)));

    // a squash empties the branch queue, so redirects never come back to back
    assert property (@(posedge clk) disable iff (rst) fl.redirect |=> !fl.redirect);

endmodule

// File: logic/ooo_core_top.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module ooo_core_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  logic [`WB_ADR_W-1:0] adr,
    input  logic [`XLEN-1:0]     dat_w,
    output logic [`XLEN-1:0]     dat_r,
    output logic                 ack,
    output logic                 commit_valid,
    output logic [`XLEN-1:0]     commit_pc,
    output logic [`RD_W-1:0]     commit_rd,
    output logic [`XLEN-1:0]     commit_value,
    output logic                 redirect,
    output logic [`XLEN-1:0]     redirect_pc
);
    // issue, result and flush traffic between the three blocks
    cdb_if cdb ();

    // host port, decode and pc
    dispatch_decode u_decode (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .dec   (cdb.decode),
        .fl    (cdb.flush)
    );

    exec_unit u_exec (
        .clk (clk),
        .rst (rst),
        .ex  (cdb.exec)
    );

    reorder_buffer u_rob (
        .clk          (clk),
        .rst          (rst),
        .rb           (cdb.rob),
        .fl           (cdb.flush),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    // redirect is visible to the host for checking
    assign redirect    = cdb.redirect;
    assign redirect_pc = cdb.redirect_pc;

endmodule

// File: sim/tb_host_tasks.svh
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// classic cycle, request held until the slave acks
task automatic wb_write(input logic [`WB_ADR_W-1:0] a, input logic [`XLEN-1:0] d);
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= 1'b1;
    adr   <= a;
    dat_w <= d;
    @(negedge clk);
    while (!ack) begin
        @(negedge clk);
    end
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
endtask

// read data is checked by the monitor against the model pc
task automatic wb_read(input logic [`WB_ADR_W-1:0] a);
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= a;
    @(negedge clk);
    while (!ack) begin
        @(negedge clk);
    end
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
endtask

// rv32i encodings, register fields are don't care here
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {imm, 5'd1, f3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] off, input logic [2:0] f3);
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
endfunction

// what the next acked instruction should look like at commit
task automatic expect_instr(input logic legal, input logic is_br, input logic taken,
                            input logic [4:0] rd, input logic [31:0] value,
                            input logic [31:0] off);
    pend_legal = legal;
    pend       = '0;
    pend.is_br = is_br;
    pend.taken = taken;
    pend.rd    = rd;
    pend.value = value;
    pend.target = off;
endtask

// nine instruction writes back to back behind a branch at the head
task automatic run_burst();
    logic [31:0] a;
    logic [31:0] b;
    a = 32'h1234_5678;
    b = 32'h0000_0001;
    wb_write(`WB_ADDR_OPA, a);
    wb_write(`WB_ADDR_OPB, b);
    // beq on unequal operands, not taken
    expect_instr(1'b1, 1'b1, 1'b0, 5'd0, 32'd0, 32'd16);
    wb_write(`WB_ADDR_INSTR, b_type(13'd16, 3'b000));
    for (int i = 0; i < 8; i++) begin
        expect_instr(1'b1, 1'b0, 1'b0, 5'(i + 1), a + b, 32'd0);
        wb_write(`WB_ADDR_INSTR, r_type(7'b0000000, 3'b000, 5'(i + 1)));
    end
endtask

`endif

// File: sim/tb_ooo_core.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module tb_ooo_core;

    localparam int NUM_INSTR     = 400;
    localparam int CLK_PERIOD    = 40;
    // cycles allowed per instruction, operand writes and redirects included
    localparam int CYC_PER_INSTR = 20;

    // one expected reorder entry
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`RD_W-1:0] rd;
        logic [`XLEN-1:0] value;
        logic             is_br;
        logic             taken;
        // holds the offset until the entry gets its pc
        logic [`XLEN-1:0] target;
        logic             redirected;
    } entry_t;

    logic                 clk;
    logic                 rst;
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [`WB_ADR_W-1:0] adr;
    logic [`XLEN-1:0]     dat_w;
    logic [`XLEN-1:0]     dat_r;
    logic                 ack;
    logic                 commit_valid;
    logic [`XLEN-1:0]     commit_pc;
    logic [`RD_W-1:0]     commit_rd;
    logic [`XLEN-1:0]     commit_value;
    logic                 redirect;
    logic [`XLEN-1:0]     redirect_pc;

    // reference model, oldest live entry at the front
    entry_t           model_q [$];
    logic [`XLEN-1:0] model_pc;
    logic [`XLEN-1:0] reload_pc;
    logic             reload_due;
    logic             saw_redirect;
    logic [31:0]      rng;

    // instruction the host is writing right now
    entry_t           pend;
    logic             pend_legal;

    // bus state seen at the previous falling edge
    logic             prev_req;
    logic             prev_instr;
    logic             prev_read;
    logic             prev_redirect;
    int               prev_occ;
    logic [`XLEN-1:0] prev_pc;

    ooo_core_top dut (
        .clk          (clk),
        .rst          (rst),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .dat_w        (dat_w),
        .dat_r        (dat_r),
        .ack          (ack),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    `include "tb_host_tasks.svh"

    // random op, operands, rd and offset, about three in sixteen are branches
    task automatic send_random_instr();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] off;
        logic [31:0] word;
        logic        taken;
        r   = rand_word();
        a   = rand_word();
        b   = rand_word();
        imm = {{20{r[31]}}, r[31:20]};
        off = {{19{r[28]}}, r[28:18], 2'b00};
        case (r[11:8])
            4'd0, 4'd1, 4'd2: begin
                // equal operands for half of them so both outcomes show up
                if (r[13]) begin
                    b = a;
                end
                taken = r[12] ? (a != b) : (a == b);
                word  = b_type(off[12:0], r[12] ? 3'b001 : 3'b000);
                expect_instr(1'b1, 1'b1, taken, 5'd0, 32'd0, off);
            end
            4'd3: begin
                // load opcode, outside the subset
                word = {r[31:7], 7'b0000011};
                expect_instr(1'b0, 1'b0, 1'b0, 5'd0, 32'd0, 32'd0);
            end
            4'd4, 4'd5, 4'd6: begin
                word = r_type(7'b0000000, 3'b000, r[4:0]);
                expect_instr(1'b1, 1'b0, 1'b0, r[4:0], a + b, 32'd0);
            end
            4'd7, 4'd8: begin
                word = r_type(7'b0100000, 3'b000, r[4:0]);
                expect_instr(1'b1, 1'b0, 1'b0, r[4:0], a - b, 32'd0);
            end
            4'd9, 4'd10: begin
                word = r_type(7'b0000000, 3'b100, r[4:0]);
                expect_instr(1'b1, 1'b0, 1'b0, r[4:0], a ^ b, 32'd0);
            end
            4'd11, 4'd12: begin
                word = i_type(r[31:20], 3'b000, r[4:0]);
                expect_instr(1'b1, 1'b0, 1'b0, r[4:0], a + imm, 32'd0);
            end
            default: begin
                word = i_type(r[31:20], 3'b100, r[4:0]);
                expect_instr(1'b1, 1'b0, 1'b0, r[4:0], a ^ imm, 32'd0);
            end
        endcase
        wb_write(`WB_ADDR_OPA, a);
        wb_write(`WB_ADDR_OPB, b);
        wb_write(`WB_ADDR_INSTR, word);
    endtask

    // one falling edge of the monitor, registered outputs are stable here
    task automatic observe_edge();
        entry_t e;
        int     br;
        logic   exp_ack;
        // pc reload lands one edge after the redirect pulse rises
        if (reload_due) begin
            model_pc   = reload_pc;
            reload_due = 1'b0;
        end
        if (commit_valid) begin
            if (model_q.size() == 0) begin
                stop_run("a commit appeared with no instruction outstanding");
            end
            e = model_q.pop_front();
            check_value("commit_pc", commit_pc, e.pc);
            check_value("commit_rd", 32'(commit_rd), 32'(e.rd));
            if (!e.is_br) begin
                check_value("commit_value", commit_value, e.value);
            end
            if (e.is_br && e.taken && !e.redirected) begin
                stop_run("a taken branch retired without a redirect");
            end
        end
        // slot free and no redirect pulse at the edge, else an instruction waits
        exp_ack = prev_req && (!prev_instr || !pend_legal ||
                               (prev_occ < `ROB_DEPTH && !prev_redirect));
        check_value("ack", 32'(ack), 32'(exp_ack));
        if (ack && prev_instr && pend_legal) begin
            e        = pend;
            e.pc     = model_pc;
            e.target = model_pc + pend.target;
            model_q.push_back(e);
            model_pc = model_pc + 32'd4;
        end
        if (ack && prev_read) begin
            check_value("dat_r", dat_r, prev_pc);
        end
        if (redirect) begin
            // the oldest taken branch that has not redirected yet
            br = -1;
            for (int i = 0; i < model_q.size(); i++) begin
                if (br < 0 && model_q[i].is_br && model_q[i].taken && !model_q[i].redirected) begin
                    br = i;
                end
            end
            if (br < 0) begin
                stop_run("a redirect appeared with no taken branch outstanding");
            end
            check_value("redirect_pc", redirect_pc, model_q[br].target);
            e            = model_q[br];
            e.redirected = 1'b1;
            model_q[br]  = e;
            // younger work is squashed and never commits
            while (model_q.size() > br + 1) begin
                void'(model_q.pop_back());
            end
            reload_pc    = e.target;
            reload_due   = 1'b1;
            saw_redirect = 1'b1;
        end
        prev_req      = cyc && stb && !ack;
        prev_instr    = prev_req && we && (adr == `WB_ADDR_INSTR);
        prev_read     = prev_req && !we;
        prev_redirect = redirect;
        prev_occ      = model_q.size();
        prev_pc       = model_pc;
    endtask

    initial begin
        prev_req      = 1'b0;
        prev_instr    = 1'b0;
        prev_read     = 1'b0;
        prev_redirect = 1'b0;
        prev_occ      = 0;
        prev_pc       = '0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                observe_edge();
            end
        end
    end

    // watchdog sized from the instruction count
    initial begin
        #(NUM_INSTR * CYC_PER_INSTR * CLK_PERIOD);
        stop_run("timeout: the run did not finish within the cycle budget");
    end

    initial begin
        rng          = 32'd89682;
        rst          = 1'b1;
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = '0;
        dat_w        = '0;
        model_pc     = '0;
        reload_pc    = '0;
        reload_due   = 1'b0;
        saw_redirect = 1'b0;
        pend         = '0;
        pend_legal   = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        run_burst();
        for (int n = 0; n < NUM_INSTR; n++) begin
            send_random_instr();
            // pc read back after a reload
            if (saw_redirect) begin
                saw_redirect = 1'b0;
                wb_read(`WB_ADDR_OPA);
            end
        end
        // drain, then idle a while so stray commits get caught
        while (model_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
        $display("Regression passed");
        $finish;
    end

endmodule

// File: list.f
+incdir+logic
+incdir+sim
logic/rv32i_pkg.sv
logic/tomasulo_pkg.sv
logic/cdb_if.sv
logic/sync_fifo.sv
logic/dispatch_decode.sv
logic/exec_unit.sv
logic/reorder_buffer.sv
logic/ooo_core_top.sv
sim/tb_ooo_core.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_ooo_core
FILELIST   := list.f
OBJ_DIR    := obj_dir
COMMON     := --timescale 1ns/1ps --assert --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only --timing $(COMMON)
SIM_FLAGS  := --binary -j 0 -Mdir $(OBJ_DIR) $(COMMON)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS)

# the simulator exits non-zero on $$fatal, so make fails with it
sim:
	$(VERILATOR) $(SIM_FLAGS)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
